/* src/x86_dec_pkg.sv */
package x86_dec_pkg;

  localparam int APB_ADDR_W = 4;                         // Byte address, four registers
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] REG_BYTE     = 4'h0; // Instruction byte in, write only
  localparam logic [APB_ADDR_W-1:0] REG_UOP_CTRL = 4'h4; // Head uop fields, no pop
  localparam logic [APB_ADDR_W-1:0] REG_UOP_IMM  = 4'h8; // Head imm, pops
  localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 4'hC; // Count, busy, err

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_CNT_W = 4;                         // Must hold 0..FIFO_DEPTH
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int STACK_STEP = 8;                         // RSP move per push or pop

  // Micro-operation codes
  typedef enum logic [3:0] {
    MIOP_NOP,
    MIOP_ALUI,                                           // ALU op with immediate
    MIOP_MOVI,
    MIOP_ADDI,                                           // Used for RSP adjust
    MIOP_LOAD,
    MIOP_STORE,
    MIOP_J,
    MIOP_JCC,                                            // Condition in sub
    MIOP_JCX,
    MIOP_JR                                              // Jump to register s
  } miop_t;

  // Same order as opcode bits 5:3
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_OR,
    ALU_ADC,
    ALU_SBB,
    ALU_AND,
    ALU_SUB,
    ALU_XOR,
    ALU_CMP
  } alu_t;

  typedef logic [3:0] rega_t;                            // {REX.B, reg[2:0]}

  localparam rega_t RAX = 4'd0;
  localparam rega_t RSP = 4'd4;
  localparam rega_t TMP = 4'd14;                         // Scratch, not visible to ISA
  localparam rega_t RIP = 4'd15;

  typedef enum logic [1:0] {
    BMD_08,
    BMD_32,
    BMD_64
  } bmd_t;

  // Decoded instruction classes
  typedef enum logic [3:0] {
    CLS_ALU_IMM,
    CLS_PUSH_R,
    CLS_POP_R,
    CLS_PUSH_I,
    CLS_MOV_I,
    CLS_JCC,
    CLS_JCX,
    CLS_JMP,
    CLS_CALL,
    CLS_RET
  } icls_t;

  typedef struct packed {
    miop_t              op;
    logic [3:0]         sub;                             // ALU op or condition code
    rega_t              d;
    rega_t              s;
    bmd_t               bmd;
    logic signed [31:0] imm;                             // Immediate or displacement
  } uop_t;                                               // 50 bits

endpackage

/* src/dec_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface dec_if;
  import x86_dec_pkg::*;

  logic               valid;
  logic               ready;
  icls_t              cls;
  rega_t              regn;                              // Register from opcode low bits
  logic [3:0]         sub;
  bmd_t               bmd;
  logic signed [31:0] imm;                               // Sign-extended operand

  modport src (output valid, cls, regn, sub, bmd, imm, input ready);
  modport dst (input valid, cls, regn, sub, bmd, imm, output ready);
endinterface

`default_nettype wire

/* src/apb_port.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_port (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [x86_dec_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [x86_dec_pkg::APB_DATA_W-1:0] pwdata,
  output logic [x86_dec_pkg::APB_DATA_W-1:0] prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               byte_valid,
  output logic [7:0]                         byte_data,
  input  logic                               byte_ready,
  input  x86_dec_pkg::uop_t                  head,
  input  logic                               empty,
  input  logic [x86_dec_pkg::FIFO_CNT_W-1:0] count,
  input  logic                               busy,
  input  logic                               bad_opcode,
  output logic                               pop
);
  import x86_dec_pkg::*;

  logic access;
  logic wr_byte;
  logic rd_uop;
  logic clr_err;
  logic err;                                             // Sticky bad opcode flag

  assign access  = psel & penable;                       // Access phase
  assign wr_byte = access & pwrite & (paddr == REG_BYTE);
  assign rd_uop  = access & ~pwrite & ((paddr == REG_UOP_CTRL) | (paddr == REG_UOP_IMM));
  assign clr_err = access & pwrite & (paddr == REG_STATUS) & pwdata[9];

  assign pready  = wr_byte ? (byte_valid & byte_ready) : 1'b1; // Byte write waits for decoder
  assign pslverr = rd_uop & empty;                       // Nothing queued
  assign pop     = access & ~pwrite & (paddr == REG_UOP_IMM) & ~empty;

  always_comb
  begin
    case (paddr)
      REG_UOP_CTRL: prdata = {14'd0, head.bmd, head.s, head.d, head.sub, head.op};
      REG_UOP_IMM:  prdata = head.imm;
      REG_STATUS:   prdata = {22'd0, err, busy, 4'd0, count};
      default:      prdata = '0;                         // Byte reg and holes read zero
    endcase
  end

  // Byte goes out one cycle into the access phase
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      byte_valid <= 1'b0;
      err        <= 1'b0;
    end
    else
    begin
      if (byte_valid && byte_ready)
        byte_valid <= 1'b0;                              // Taken, write completes now
      else if (wr_byte && !byte_valid)
        byte_valid <= 1'b1;
      if (bad_opcode)
        err <= 1'b1;                                     // Set wins over clear
      else if (clr_err)
        err <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_byte && !byte_valid)
      byte_data <= pwdata[7:0];
  end

  // Offered byte stays until the decoder takes it
  a_byte_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (byte_valid && !byte_ready) |=> (byte_valid && $stable(byte_data)));
endmodule

`default_nettype wire

/* src/byte_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_decode (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,
  dec_if.src         dec,
  output logic       busy_part,
  output logic       bad_opcode
);
  import x86_dec_pkg::*;

  typedef enum logic {
    OPCODE,
    OPERAND
  } state_t;

  state_t     state;
  logic       rex_v;                                     // REX seen for this instruction
  logic       rex_w;
  logic       rex_b;
  logic       wide;                                      // Operand is four bytes
  logic [1:0] idx;                                       // Next operand byte
  logic       take;
  logic       last;
  logic       post;
  alu_t       alu_op;
  logic       op_rex;
  logic       op_ok;
  icls_t      op_cls;
  logic [3:0] op_sub;
  bmd_t       op_bmd;
  logic       op_has;                                    // Operand bytes follow
  logic       op_wide;

  function automatic bmd_t bmd_det(input logic byte_form, input logic w);
    return byte_form ? BMD_08 : (w ? BMD_64 : BMD_32);
  endfunction

  assign byte_ready = ~dec.valid | dec.ready;            // Hold off while result unsent
  assign take       = byte_valid & byte_ready;
  assign busy_part  = (state == OPERAND) | rex_v;
  assign alu_op     = alu_t'(byte_data[5:3]);

  // Opcode classification
  always_comb
  begin
    op_rex  = 1'b0;
    op_ok   = 1'b1;
    op_cls  = CLS_JMP;
    op_sub  = 4'd0;
    op_bmd  = bmd_det(1'b0, rex_w);                      // Plain 32/64 form
    op_has  = 1'b1;
    op_wide = 1'b0;
    casez (byte_data)
      8'h4?:
        op_rex = 1'b1;                                   // Only W and B kept
      8'b00???10?:                                       // ALU on AL/eAX with imm
      begin
        op_cls  = CLS_ALU_IMM;
        op_sub  = {1'b0, alu_op};
        op_bmd  = bmd_det(~byte_data[0], rex_w);
        op_wide = byte_data[0];
      end
      8'h5?:                                             // Bit 3 picks POP
      begin
        op_cls = byte_data[3] ? CLS_POP_R : CLS_PUSH_R;
        op_bmd = BMD_64;
        op_has = 1'b0;
      end
      8'h68, 8'h6a:                                      // PUSH imm32 / imm8
      begin
        op_cls  = CLS_PUSH_I;
        op_bmd  = BMD_64;
        op_wide = ~byte_data[1];
      end
      8'h7?:
      begin
        op_cls = CLS_JCC;
        op_sub = byte_data[3:0];                         // Condition nibble
      end
      8'hb?:                                             // MOV imm to r8 / r32 / r64
      begin
        op_cls  = CLS_MOV_I;
        op_bmd  = bmd_det(~byte_data[3], rex_w);
        op_wide = byte_data[3];
      end
      8'hc3:
      begin
        op_cls = CLS_RET;
        op_bmd = BMD_64;
        op_has = 1'b0;
      end
      8'he3:
        op_cls = CLS_JCX;
      8'he8:
      begin
        op_cls  = CLS_CALL;
        op_bmd  = BMD_64;
        op_wide = 1'b1;                                  // rel32
      end
      8'heb:
        op_cls = CLS_JMP;
      default:
        op_ok = 1'b0;
    endcase
  end

  assign last = (state == OPERAND) ? (~wide | (idx == 2'd3)) : (op_ok & ~op_rex & ~op_has);
  assign post = take & last;                             // Final byte of an instruction

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= OPCODE;
      rex_v      <= 1'b0;
      rex_w      <= 1'b0;
      rex_b      <= 1'b0;
      dec.valid  <= 1'b0;
      bad_opcode <= 1'b0;
    end
    else
    begin
      bad_opcode <= take & (state == OPCODE) & ~op_ok;   // One-cycle pulse
      if (post)
        dec.valid <= 1'b1;
      else if (dec.ready)
        dec.valid <= 1'b0;
      if (post || (take && (state == OPCODE) && !op_ok))
      begin
        state <= OPCODE;
        rex_v <= 1'b0;                                   // REX applies to one opcode
        rex_w <= 1'b0;
        rex_b <= 1'b0;
      end
      else if (take && (state == OPCODE) && op_rex)
      begin
        rex_v <= 1'b1;
        rex_w <= byte_data[3];
        rex_b <= byte_data[0];
      end
      else if (take && (state == OPCODE))
        state <= OPERAND;
    end
  end

  // Payload regs also assemble the operand
  always_ff @(posedge clk)
  begin
    if (take && (state == OPCODE) && op_ok && !op_rex)
    begin
      dec.cls  <= op_cls;
      dec.regn <= {rex_b, byte_data[2:0]};
      dec.sub  <= op_sub;
      dec.bmd  <= op_bmd;
      dec.imm  <= '0;
      wide     <= op_wide;
      idx      <= 2'd0;
    end
    else if (take && (state == OPERAND))
    begin
      if (wide)
        dec.imm[idx*8 +: 8] <= byte_data;                // Little-endian
      else
        dec.imm <= {{24{byte_data[7]}}, byte_data};
      idx <= idx + 2'd1;
    end
  end

  // Pending instruction holds until the emitter takes it
  a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (dec.valid && !dec.ready) |=> (dec.valid && $stable(dec.cls) && $stable(dec.regn)
      && $stable(dec.sub) && $stable(dec.bmd) && $stable(dec.imm)));
endmodule

`default_nettype wire

/* src/uop_emit.sv */
`timescale 1ns/10ps
`default_nettype none

module uop_emit (
  input  logic              clk,
  input  logic              rst_n,
  dec_if.dst                dec,
  output logic              push_valid,
  input  logic              push_ready,
  output x86_dec_pkg::uop_t push_uop,
  output logic              busy_emit
);
  import x86_dec_pkg::*;

  icls_t              cls_q;
  rega_t              reg_q;
  logic [3:0]         sub_q;
  bmd_t               bmd_q;
  logic signed [31:0] imm_q;
  logic               active;                            // Sequence in progress
  logic [1:0]         step;
  logic [1:0]         last_step;

  function automatic uop_t mk(
    input miop_t              op,
    input logic [3:0]         sub,
    input rega_t              d,
    input rega_t              s,
    input bmd_t               bmd,
    input logic signed [31:0] imm
  );
    return '{op, sub, d, s, bmd, imm};
  endfunction

  // RSP adjust, always full width
  function automatic uop_t sp_adj(input logic signed [31:0] amt);
    return mk(MIOP_ADDI, 4'd0, RSP, RSP, BMD_64, amt);
  endfunction

  assign dec.ready  = ~active;                           // One instruction at a time
  assign push_valid = active;
  assign busy_emit  = active;

  always_comb
  begin
    push_uop  = mk(MIOP_NOP, 4'd0, 4'd0, 4'd0, BMD_08, 32'sd0);
    last_step = 2'd0;
    case (cls_q)
      CLS_ALU_IMM: push_uop = mk(MIOP_ALUI, sub_q, RAX, RAX, bmd_q, imm_q);
      CLS_MOV_I:   push_uop = mk(MIOP_MOVI, 4'd0, reg_q, 4'd0, bmd_q, imm_q);
      CLS_JCC:     push_uop = mk(MIOP_JCC, sub_q, 4'd0, 4'd0, bmd_q, imm_q);
      CLS_JCX:     push_uop = mk(MIOP_JCX, 4'd0, 4'd0, 4'd0, bmd_q, imm_q);
      CLS_JMP:     push_uop = mk(MIOP_J, 4'd0, 4'd0, 4'd0, bmd_q, imm_q);
      CLS_PUSH_R:
      begin
        last_step = 2'd1;
        if (step == 2'd0)
          push_uop = sp_adj(-STACK_STEP);                // Make room first
        else
          push_uop = mk(MIOP_STORE, 4'd0, reg_q, RSP, bmd_q, 32'sd0);
      end
      CLS_POP_R:
      begin
        last_step = 2'd1;
        if (step == 2'd0)
          push_uop = mk(MIOP_LOAD, 4'd0, reg_q, RSP, bmd_q, 32'sd0);
        else
          push_uop = sp_adj(STACK_STEP);
      end
      CLS_PUSH_I:                                        // Via TMP
      begin
        last_step = 2'd2;
        case (step)
          2'd0:    push_uop = mk(MIOP_MOVI, 4'd0, TMP, 4'd0, bmd_q, imm_q);
          2'd1:    push_uop = sp_adj(-STACK_STEP);
          default: push_uop = mk(MIOP_STORE, 4'd0, TMP, RSP, bmd_q, 32'sd0);
        endcase
      end
      CLS_CALL:                                          // Push return address, jump
      begin
        last_step = 2'd2;
        case (step)
          2'd0:    push_uop = sp_adj(-STACK_STEP);
          2'd1:    push_uop = mk(MIOP_STORE, 4'd0, RIP, RSP, bmd_q, 32'sd0);
          default: push_uop = mk(MIOP_J, 4'd0, 4'd0, 4'd0, bmd_q, imm_q);
        endcase
      end
      CLS_RET:
      begin
        last_step = 2'd2;
        case (step)
          2'd0:    push_uop = mk(MIOP_LOAD, 4'd0, TMP, RSP, bmd_q, 32'sd0);
          2'd1:    push_uop = sp_adj(STACK_STEP);
          default: push_uop = mk(MIOP_JR, 4'd0, 4'd0, TMP, bmd_q, 32'sd0);
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      step   <= 2'd0;
    end
    else if (dec.valid && dec.ready)
    begin
      active <= 1'b1;
      step   <= 2'd0;
    end
    else if (push_valid && push_ready)
    begin
      if (step == last_step)
        active <= 1'b0;                                  // Sequence done
      step <= step + 2'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (dec.valid && dec.ready)
    begin
      cls_q <= dec.cls;
      reg_q <= dec.regn;
      sub_q <= dec.sub;
      bmd_q <= dec.bmd;
      imm_q <= dec.imm;
    end
  end

  // Stalled by a full queue, the uop must not change
  a_push_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (push_valid && !push_ready) |=> (push_valid && $stable(push_uop)));
endmodule

`default_nettype wire

/* src/uop_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module uop_fifo (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               push_valid,
  output logic                               push_ready,
  input  x86_dec_pkg::uop_t                  push_uop,
  input  logic                               pop,
  output x86_dec_pkg::uop_t                  head,
  output logic [x86_dec_pkg::FIFO_CNT_W-1:0] count,
  output logic                               empty
);
  import x86_dec_pkg::*;

  uop_t                  mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;                         // Wraps at depth, power of two
  logic                  do_push;
  logic                  do_pop;

  assign push_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign empty      = (count == '0);
  assign head       = mem[rd_ptr];                       // Show-ahead
  assign do_push    = push_valid & push_ready;
  assign do_pop     = pop & ~empty;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                                       // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_uop;
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    count <= FIFO_CNT_W'(FIFO_DEPTH));
endmodule

`default_nettype wire

/* src/x86_decoder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module x86_decoder_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [x86_dec_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [x86_dec_pkg::APB_DATA_W-1:0] pwdata,
  output logic [x86_dec_pkg::APB_DATA_W-1:0] prdata,
  output logic                               pready,
  output logic                               pslverr
);
  import x86_dec_pkg::*;

  logic                  byte_valid;
  logic [7:0]            byte_data;
  logic                  byte_ready;
  logic                  busy_part;
  logic                  busy_emit;
  logic                  busy;
  logic                  bad_opcode;
  logic                  push_valid;
  logic                  push_ready;
  uop_t                  push_uop;
  uop_t                  head;
  logic [FIFO_CNT_W-1:0] count;
  logic                  empty;
  logic                  pop;

  dec_if u_dec_if ();

  assign busy = busy_part | u_dec_if.valid | busy_emit;  // Anything in flight

  apb_port u_apb_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready),
    .head       (head),
    .empty      (empty),
    .count      (count),
    .busy       (busy),
    .bad_opcode (bad_opcode),
    .pop        (pop)
  );

  byte_decode u_byte_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready),
    .dec        (u_dec_if),
    .busy_part  (busy_part),
    .bad_opcode (bad_opcode)
  );

  uop_emit u_uop_emit (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec        (u_dec_if),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_uop   (push_uop),
    .busy_emit  (busy_emit)
  );

  uop_fifo u_uop_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_uop   (push_uop),
    .pop        (pop),
    .head       (head),
    .count      (count),
    .empty      (empty)
  );
endmodule

`default_nettype wire

/* verification/tb_x86_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_x86_decoder;
  import x86_dec_pkg::*;

  localparam int MAX_ENTRIES = 96;
  localparam int READY_LIMIT = 64;                       // Cycles an APB access may wait
  localparam int POLL_LIMIT  = 32;                       // Status polls per wait

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  logic [7:0]  t_bytes [MAX_ENTRIES][6];                 // Instruction bytes in order
  int          t_nbytes [MAX_ENTRIES];
  int          t_nuops [MAX_ENTRIES];
  logic [31:0] t_ctrl [MAX_ENTRIES][3];                  // Expected CTRL words
  logic [31:0] t_imm [MAX_ENTRIES][3];
  int          n_entries;
  int          main_entries;                             // Rest are back-pressure entries
  logic [31:0] rng_state;

  x86_decoder_top u_x86_decoder_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #50 clk = ~clk;                                 // 100 ns period

  task automatic fail_stop();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic fail_with(input string why);
    $display("%s", why);
    fail_stop();
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      fail_stop();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Register map layout of REG_UOP_CTRL
  function automatic logic [31:0] ctrl_word(input logic [3:0] op, input logic [3:0] sub,
                                            input logic [3:0] d, input logic [3:0] s,
                                            input logic [1:0] bmd);
    return {14'd0, bmd, s, d, sub, op};
  endfunction

  function automatic logic [31:0] imm_of(input logic [31:0] v, input logic wide);
    return wide ? v : {{24{v[7]}}, v[7:0]};              // Short operands sign-extend
  endfunction

  task automatic begin_entry();
    t_nbytes[n_entries] = 0;
    t_nuops[n_entries]  = 0;
  endtask

  task automatic close_entry();
    n_entries++;
  endtask

  task automatic add_byte(input logic [7:0] b);
    t_bytes[n_entries][t_nbytes[n_entries]] = b;
    t_nbytes[n_entries]++;
  endtask

  task automatic add_uop(input logic [31:0] c, input logic [31:0] i);
    t_ctrl[n_entries][t_nuops[n_entries]] = c;
    t_imm[n_entries][t_nuops[n_entries]]  = i;
    t_nuops[n_entries]++;
  endtask

  task automatic add_operand(input logic [31:0] v, input logic wide);
    add_byte(v[7:0]);                                    // Little-endian
    if (wide)
    begin
      add_byte(v[15:8]);
      add_byte(v[23:16]);
      add_byte(v[31:24]);
    end
  endtask

  task automatic rex_prefix(input logic w, input logic b);
    if (w || b)
      add_byte({4'h4, w, 2'b00, b});
  endtask

  task automatic add_push_pair(input logic [3:0] r);
    add_uop(ctrl_word(MIOP_ADDI, 4'd0, RSP, RSP, BMD_64), 32'hffff_fff8);
    add_uop(ctrl_word(MIOP_STORE, 4'd0, r, RSP, BMD_64), 32'd0);
  endtask

  task automatic build_alu(input logic [2:0] k, input logic wide, input logic w);
    logic [31:0] v;
    logic [1:0]  bmd;
    begin_entry();
    rex_prefix(w, 1'b0);
    add_byte({2'b00, k, 2'b10, wide});                   // 0x04/0x05 + 8k
    draw(v);
    add_operand(v, wide);
    bmd = !wide ? BMD_08 : (w ? BMD_64 : BMD_32);
    add_uop(ctrl_word(MIOP_ALUI, {1'b0, k}, RAX, RAX, bmd), imm_of(v, wide));
    close_entry();
  endtask

  task automatic build_push_r(input logic [3:0] r);
    begin_entry();
    rex_prefix(1'b0, r[3]);
    add_byte({5'b01010, r[2:0]});
    add_push_pair(r);
    close_entry();
  endtask

  task automatic build_pop_r(input logic [3:0] r);
    begin_entry();
    rex_prefix(1'b0, r[3]);
    add_byte({5'b01011, r[2:0]});
    add_uop(ctrl_word(MIOP_LOAD, 4'd0, r, RSP, BMD_64), 32'd0);
    add_uop(ctrl_word(MIOP_ADDI, 4'd0, RSP, RSP, BMD_64), 32'd8);
    close_entry();
  endtask

  task automatic build_push_i(input logic wide);
    logic [31:0] v;
    begin_entry();
    add_byte(wide ? 8'h68 : 8'h6a);
    draw(v);
    add_operand(v, wide);
    add_uop(ctrl_word(MIOP_MOVI, 4'd0, TMP, 4'd0, BMD_64), imm_of(v, wide));
    add_push_pair(TMP);
    close_entry();
  endtask

  task automatic build_mov_i(input logic [3:0] r, input logic wide, input logic w);
    logic [31:0] v;
    logic [1:0]  bmd;
    begin_entry();
    rex_prefix(w, r[3]);
    add_byte({4'hb, wide, r[2:0]});
    draw(v);
    add_operand(v, wide);
    bmd = !wide ? BMD_08 : (w ? BMD_64 : BMD_32);
    add_uop(ctrl_word(MIOP_MOVI, 4'd0, r, 4'd0, bmd), imm_of(v, wide));
    close_entry();
  endtask

  // Jcc, JCX and JMP with rel8
  task automatic build_branch(input logic [7:0] opc, input logic [3:0] op, input logic [3:0] sub);
    logic [31:0] v;
    begin_entry();
    add_byte(opc);
    draw(v);
    add_operand(v, 1'b0);
    add_uop(ctrl_word(op, sub, 4'd0, 4'd0, BMD_32), imm_of(v, 1'b0));
    close_entry();
  endtask

  task automatic build_call();
    logic [31:0] v;
    begin_entry();
    add_byte(8'he8);
    draw(v);
    add_operand(v, 1'b1);
    add_push_pair(RIP);                                  // Return address onto stack
    add_uop(ctrl_word(MIOP_J, 4'd0, 4'd0, 4'd0, BMD_64), v);
    close_entry();
  endtask

  task automatic build_ret();
    begin_entry();
    add_byte(8'hc3);
    add_uop(ctrl_word(MIOP_LOAD, 4'd0, TMP, RSP, BMD_64), 32'd0);
    add_uop(ctrl_word(MIOP_ADDI, 4'd0, RSP, RSP, BMD_64), 32'd8);
    add_uop(ctrl_word(MIOP_JR, 4'd0, 4'd0, TMP, BMD_64), 32'd0);
    close_entry();
  endtask

  task automatic build_table();
    for (int k = 0; k < 8; k++)
    begin
      build_alu(3'(k), 1'b0, 1'b0);
      build_alu(3'(k), 1'b1, 1'b0);
      build_alu(3'(k), 1'b1, 1'b1);
    end
    build_alu(3'd5, 1'b0, 1'b1);                         // Byte form ignores REX.W
    build_push_r(4'd0);
    build_push_r(4'd3);
    build_push_r(4'd9);
    build_push_r(4'd15);
    build_pop_r(4'd1);
    build_pop_r(4'd7);
    build_pop_r(4'd8);
    build_pop_r(4'd12);
    build_push_i(1'b0);
    build_push_i(1'b1);
    build_mov_i(4'd2, 1'b0, 1'b0);
    build_mov_i(4'd6, 1'b1, 1'b0);
    build_mov_i(4'd11, 1'b1, 1'b0);
    build_mov_i(4'd9, 1'b1, 1'b1);
    for (int cc = 0; cc < 16; cc++)
      build_branch(8'h70 | 8'(cc), MIOP_JCC, 4'(cc));
    build_branch(8'he3, MIOP_JCX, 4'd0);
    build_branch(8'heb, MIOP_J, 4'd0);
    build_call();
    build_ret();
    main_entries = n_entries;
    for (int k = 0; k < 12; k++)
      build_push_r(4'(k % 8));                           // One byte each
  endtask

  // One APB transfer with pready sampled at the falling edge
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready)
    begin
      if (waited == READY_LIMIT)
        fail_with("Timeout: pready stayed low during an APB transfer");
      else
      begin
        waited++;
        @(negedge clk);
      end
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_xfer(1'b1, addr, wdata, rdata, slverr);
    check({31'd0, slverr}, 32'd0, "pslverr on write");
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                          output logic slverr);
    apb_xfer(1'b0, addr, 32'd0, rdata, slverr);
  endtask

  // Byte write that gives up after max_wait cycles and withdraws the request
  task automatic write_byte_or_stall(input logic [7:0] b, input int max_wait,
                                     output logic done);
    int waited;
    waited = 0;
    done   = 1'b0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= REG_BYTE;
    pwdata  <= {24'd0, b};
    @(posedge clk);
    penable <= 1'b1;
    while (!done && waited < max_wait)
    begin
      @(negedge clk);
      done = pready;
      waited++;
    end
    @(posedge clk);
    psel    <= 1'b0;                                     // Offered byte stays in apb_port
    penable <= 1'b0;
  endtask

  task automatic read_status(output logic [31:0] st);
    logic slverr;
    apb_read(REG_STATUS, st, slverr);
  endtask

  task automatic wait_for_uop();
    logic [31:0] st;
    int          polls;
    polls = 0;
    read_status(st);
    while (st[3:0] == 4'd0)
    begin
      if (polls == POLL_LIMIT)
        fail_with("Timeout: no micro-operation reached the queue");
      else
      begin
        polls++;
        read_status(st);
      end
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    polls = 0;
    read_status(st);
    while (st[8])
    begin
      if (polls == POLL_LIMIT)
        fail_with("Timeout: decoder stayed busy");
      else
      begin
        polls++;
        read_status(st);
      end
    end
  endtask

  task automatic read_uops(input int e);
    logic [31:0] rd;
    logic        slverr;
    for (int u = 0; u < t_nuops[e]; u++)
    begin
      wait_for_uop();
      apb_read(REG_UOP_CTRL, rd, slverr);
      check(rd, t_ctrl[e][u], $sformatf("entry %0d uop %0d ctrl", e, u));
      check({31'd0, slverr}, 32'd0, "pslverr on ctrl read");
      apb_read(REG_UOP_IMM, rd, slverr);
      check(rd, t_imm[e][u], $sformatf("entry %0d uop %0d imm", e, u));
      check({31'd0, slverr}, 32'd0, "pslverr on imm read");
    end
  endtask

  task automatic apply_entry(input int e);
    for (int b = 0; b < t_nbytes[e]; b++)
      apb_write(REG_BYTE, {24'd0, t_bytes[e][b]});
    read_uops(e);
  endtask

  initial
  begin
    logic [31:0] st;
    logic [31:0] rd;
    logic        slverr;
    logic        done;
    int          idx;
    int          tries;
    int          bp_first;
    clk         = 1'b0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    rng_state   = 32'd90352;
    n_entries   = 0;
    build_table();
    bp_first = main_entries;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Empty queue reads error out and pop nothing
    apb_read(REG_UOP_IMM, rd, slverr);
    check({31'd0, slverr}, 32'd1, "pslverr on empty imm read");
    apb_read(REG_UOP_CTRL, rd, slverr);
    check({31'd0, slverr}, 32'd1, "pslverr on empty ctrl read");
    read_status(st);
    check({28'd0, st[3:0]}, 32'd0, "count after empty reads");

    // Unsupported opcode then err clear
    apb_write(REG_BYTE, 32'h0000_000f);
    wait_idle();
    read_status(st);
    check({31'd0, st[9]}, 32'd1, "err after bad opcode");
    check({28'd0, st[3:0]}, 32'd0, "count after bad opcode");
    apb_write(REG_STATUS, 32'h0000_0200);
    read_status(st);
    check({31'd0, st[9]}, 32'd0, "err after clear");

    for (int e = 0; e < main_entries; e++)
      apply_entry(e);
    wait_idle();
    read_status(st);
    check({28'd0, st[3:0]}, 32'd0, "count after table");
    check({31'd0, st[9]}, 32'd0, "err after table");

    // Fill the queue without reading
    idx = bp_first;
    read_status(st);
    while (int'(st[3:0]) < FIFO_DEPTH)
    begin
      if (idx == bp_first + 8)
        fail_with("Queue never filled during back-pressure test");
      else
      begin
        apb_write(REG_BYTE, {24'd0, t_bytes[idx][0]});
        idx++;
        read_status(st);
      end
    end
    check({28'd0, st[3:0]}, FIFO_DEPTH, "count when full");
    tries = 0;
    done  = 1'b1;
    while (done)
    begin
      if (tries == 4 || idx == n_entries)
        fail_with("Byte write never stalled with a full queue");
      else
      begin
        write_byte_or_stall(t_bytes[idx][0], 16, done);
        idx++;
        tries++;
      end
    end
    read_status(st);
    check({31'd0, st[8]}, 32'd1, "busy while stalled");
    check({28'd0, st[3:0]}, FIFO_DEPTH, "count while stalled");
    for (int e = bp_first; e < idx; e++)                 // Stalled byte drains in too
      read_uops(e);
    wait_idle();
    read_status(st);
    check({28'd0, st[3:0]}, 32'd0, "count after drain");

    $display("Simulation finished: PASS");
    $finish;
  end
endmodule

`default_nettype wire

/* sim.f */
src/x86_dec_pkg.sv
src/dec_if.sv
src/apb_port.sv
src/byte_decode.sv
src/uop_emit.sv
src/uop_fifo.sv
src/x86_decoder_top.sv
verification/tb_x86_decoder.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module tb_x86_decoder -o tb_sim \
  && ./obj_dir/tb_sim | grep -q "Simulation finished: PASS" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
